//--- hw/clkPkg.sv
// ----------------------------------------
// Clock board shared definitions
// Widths of the diagnostic word fields, function
// codes and readback select codes
// ----------------------------------------
package clkPkg;

  typedef logic [2:0] diagSelT;      // Diagnostic select, DS 4..6
  typedef logic [3:0] ebusDataT;     // Load field, bus bits 32..35
  typedef logic [5:0] diagWordT;     // Readback field, bus bits 30..35
  typedef logic [7:0] burstCountT;
  typedef logic [1:0] rateSelT;      // One tick every 2**r cycles

  // Control functions 00x
  typedef enum diagSelT {
    ctlFuncStop     = 3'd0,
    ctlFuncStart    = 3'd1,
    ctlFuncStep     = 3'd2,
    ctlFuncNop3     = 3'd3,          // Was EBOX single step
    ctlFuncNop4     = 3'd4,          // Was conditional single step
    ctlFuncBurst    = 3'd5,
    ctlFuncClrReset = 3'd6,
    ctlFuncSetReset = 3'd7
  } ctlFuncE;

  // Load functions 04x
  typedef enum diagSelT {
    ldFuncBurstLo = 3'd2,            // 042
    ldFuncBurstHi = 3'd3,            // 043
    ldFuncRate    = 3'd4,            // 044
    ldFuncDisable = 3'd5,            // 045
    ldFuncNop6    = 3'd6,            // Parity checks, gone
    ldFuncNop7    = 3'd7
  } ldFuncE;

  typedef enum logic [1:0] {
    gateIdle     = 2'd0,
    gateRunning  = 2'd1,
    gateStepping = 2'd2,
    gateBursting = 2'd3
  } gateStateE;

  // Readback words
  localparam diagSelT rbStatus    = 3'd0;
  localparam diagSelT rbBurstHigh = 3'd1;
  localparam diagSelT rbBurstLow  = 3'd2;

endpackage

//--- hw/clkDiagDecode.sv
// ----------------------------------------
// Clock board diagnostic function decode
// Turns the 00x and 04x strobes into function
// pulses and keeps the master reset flop
// ----------------------------------------
`timescale 1ns/10ps

module clkDiagDecode import clkPkg::*; (
  input  logic    CLK,
  input  logic    FPGA_RESET,
  input  logic    diagCtlFunc,
  input  logic    diagLdFunc,
  input  diagSelT diagSel,
  output logic    funcStart,
  output logic    funcStop,
  output logic    funcStep,
  output logic    funcBurst,
  output logic    ldBurstLo,
  output logic    ldBurstHi,
  output logic    ldRate,
  output logic    ldDisable,
  output logic    mrReset
);

  ctlFuncE ctlCode;
  ldFuncE  ldCode;

  assign ctlCode = ctlFuncE'(diagSel);
  assign ldCode  = ldFuncE'(diagSel);

  // Anything but start drops the run mode
  assign funcStart = diagCtlFunc && (ctlCode == ctlFuncStart);
  assign funcStop  = diagCtlFunc && (ctlCode != ctlFuncStart);
  assign funcStep  = diagCtlFunc && (ctlCode == ctlFuncStep);
  assign funcBurst = diagCtlFunc && (ctlCode == ctlFuncBurst);

  assign ldBurstLo = diagLdFunc && (ldCode == ldFuncBurstLo);
  assign ldBurstHi = diagLdFunc && (ldCode == ldFuncBurstHi);
  assign ldRate    = diagLdFunc && (ldCode == ldFuncRate);
  assign ldDisable = diagLdFunc && (ldCode == ldFuncDisable);

  // Master reset flop set and cleared by diagnostic control
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      mrReset <= 1'b0;
    end else if (diagCtlFunc && (ctlCode == ctlFuncSetReset)) begin
      mrReset <= 1'b1;
    end else if (diagCtlFunc && (ctlCode == ctlFuncClrReset)) begin
      mrReset <= 1'b0;
    end
  end

  // The diagnostic channel issues one function at a time
  strobesExclusive: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    !(diagCtlFunc && diagLdFunc));

endmodule

//--- hw/clkConfigRegs.sv
// ----------------------------------------
// Clock board configuration registers
// Burst count, rate select and section
// disables, loaded from the data bus
// ----------------------------------------
`timescale 1ns/10ps

module clkConfigRegs import clkPkg::*; (
  input  logic       CLK,
  input  logic       FPGA_RESET,
  input  logic       ldBurstLo,
  input  logic       ldBurstHi,
  input  logic       ldRate,
  input  logic       ldDisable,
  input  ebusDataT   ebusData,
  output burstCountT burstCount,
  output rateSelT    rateSel,
  output logic       crmDis,
  output logic       edpDis,
  output logic       ctlDis
);

  // Burst count is loaded one nibble at a time
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      burstCount <= '0;
    end else begin
      if (ldBurstLo) begin
        burstCount[3:0] <= ebusData;    // 042
      end
      if (ldBurstHi) begin
        burstCount[7:4] <= ebusData;    // 043
      end
    end
  end

  // Rate sits in bits 34..35, source select above it is gone
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateSel <= '0;
    end else if (ldRate) begin
      rateSel <= ebusData[1:0];
    end
  end

  // Section disables, 045
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDisable) begin
      crmDis <= ebusData[2];            // Bus bit 33
      edpDis <= ebusData[1];            // Bus bit 34
      ctlDis <= ebusData[0];            // Bus bit 35
    end
  end

endmodule

//--- hw/clkGateControl.sv
// ----------------------------------------
// Clock board gate control
// Rate divider plus the run, step and burst
// machine that issues the EBOX clock pulses
// ----------------------------------------
`timescale 1ns/10ps

module clkGateControl import clkPkg::*; (
  input  logic       CLK,
  input  logic       FPGA_RESET,
  input  logic       funcStart,
  input  logic       funcStop,
  input  logic       funcStep,
  input  logic       funcBurst,
  input  burstCountT burstCount,
  input  rateSelT    rateSel,
  input  logic       crmDis,
  input  logic       edpDis,
  input  logic       ctlDis,
  output logic       eboxClk,
  output logic       crmClk,
  output logic       edpClk,
  output logic       ctlClk,
  output logic       running,
  output logic       burstActive,
  output burstCountT burstRemaining
);

  gateStateE  state;
  gateStateE  stateNext;
  burstCountT remainNext;
  logic       pulseNext;
  logic [2:0] divCount;
  logic [2:0] rateMask;
  logic       tick;

  // Free-running divider, tick when the low r bits are clear
  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 3'd1;
    end
  end

  always_comb begin
    case (rateSel)
      2'd0:    rateMask = 3'b000;       // Every cycle
      2'd1:    rateMask = 3'b001;
      2'd2:    rateMask = 3'b011;
      default: rateMask = 3'b111;       // One in eight
    endcase
  end

  assign tick = (divCount & rateMask) == 3'b000;

  always_comb begin
    stateNext  = state;
    remainNext = burstRemaining;
    pulseNext  = 1'b0;

    case (state)
      gateRunning: pulseNext = tick;
      gateStepping: begin
        if (tick) begin
          pulseNext = 1'b1;
          stateNext = gateIdle;
        end
      end
      gateBursting: begin
        if (tick) begin
          pulseNext  = 1'b1;
          remainNext = burstRemaining - 8'd1;
          if (burstRemaining == 8'd1) begin
            stateNext = gateIdle;       // Last pulse of the burst
          end
        end
      end
      default: ;
    endcase

    // A new function overrides whatever the mode was doing
    // Burst and step also raise funcStop, so they go first
    if (funcStart) begin
      stateNext = gateRunning;
      pulseNext = 1'b0;
    end else if (funcBurst) begin
      remainNext = burstCount;
      stateNext  = (burstCount == 8'd0) ? gateIdle : gateBursting;
      pulseNext  = 1'b0;
    end else if (funcStep) begin
      stateNext = gateStepping;
      pulseNext = 1'b0;
    end else if (funcStop) begin
      stateNext = gateIdle;
      pulseNext = 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      state          <= gateIdle;
      burstRemaining <= '0;
      eboxClk        <= 1'b0;
    end else begin
      state          <= stateNext;
      burstRemaining <= remainNext;
      eboxClk        <= pulseNext;
    end
  end

  assign crmClk = eboxClk && !crmDis;
  assign edpClk = eboxClk && !edpDis;
  assign ctlClk = eboxClk && !ctlDis;

  assign running     = state == gateRunning;
  assign burstActive = state == gateBursting;

  // A pulse always follows a divider tick
  pulseOnTick: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    !tick |=> !eboxClk);

  // Only a new burst function can move an empty counter
  noUnderflow: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    (burstRemaining == 8'd0 && !funcBurst) |=> burstRemaining == 8'd0);

endmodule

//--- hw/clkDiagReadback.sv
// ----------------------------------------
// Clock board diagnostic readback
// Puts status and setup on the data bus
// while a diagnostic read is active
// ----------------------------------------
`timescale 1ns/10ps

module clkDiagReadback import clkPkg::*; (
  input  logic       diagRead,
  input  diagSelT    diagSel,
  input  logic       running,
  input  logic       burstActive,
  input  logic       mrReset,
  input  rateSelT    rateSel,
  input  burstCountT burstRemaining,
  input  logic       crmDis,
  input  logic       edpDis,
  input  logic       ctlDis,
  output diagWordT   diagData,
  output logic       diagDriving
);

  assign diagDriving = diagRead;

  always_comb begin
    diagData = '0;                      // Bus idle unless read

    if (diagRead) begin
      case (diagSel)
        rbStatus: begin
          diagData = {running, burstActive, mrReset, 1'b0, rateSel};
        end
        rbBurstHigh: begin
          diagData = burstRemaining[7:2];
        end
        rbBurstLow: begin
          // Remaining low bits then the three disables
          diagData = {burstRemaining[1:0], crmDis, edpDis, ctlDis, 1'b0};
        end
        default: diagData = '0;         // Selects 3..7 read nothing now
      endcase
    end
  end

endmodule

//--- hw/clkBoard.sv
// ----------------------------------------
// Clock board top level
// Diagnostic decode, setup, gating and readback
// ----------------------------------------
`timescale 1ns/10ps

module clkBoard import clkPkg::*; (
  input  logic     CLK,
  input  logic     FPGA_RESET,
  input  logic     diagCtlFunc,
  input  logic     diagLdFunc,
  input  diagSelT  diagSel,
  input  ebusDataT ebusData,
  input  logic     diagRead,
  output logic     eboxClk,
  output logic     crmClk,
  output logic     edpClk,
  output logic     ctlClk,
  output logic     mrReset,
  output diagWordT diagData,
  output logic     diagDriving
);

  logic       funcStart;
  logic       funcStop;
  logic       funcStep;
  logic       funcBurst;
  logic       ldBurstLo;
  logic       ldBurstHi;
  logic       ldRate;
  logic       ldDisable;
  burstCountT burstCount;
  burstCountT burstRemaining;
  rateSelT    rateSel;
  logic       crmDis;
  logic       edpDis;
  logic       ctlDis;
  logic       running;
  logic       burstActive;

  clkDiagDecode u_decode (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc), .diagSel(diagSel),
    .funcStart(funcStart), .funcStop(funcStop), .funcStep(funcStep),
    .funcBurst(funcBurst), .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi),
    .ldRate(ldRate), .ldDisable(ldDisable), .mrReset(mrReset)
  );

  clkConfigRegs u_config (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET),
    .ldBurstLo(ldBurstLo), .ldBurstHi(ldBurstHi), .ldRate(ldRate),
    .ldDisable(ldDisable), .ebusData(ebusData), .burstCount(burstCount),
    .rateSel(rateSel), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis)
  );

  clkGateControl u_gate (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET),
    .funcStart(funcStart), .funcStop(funcStop), .funcStep(funcStep),
    .funcBurst(funcBurst), .burstCount(burstCount), .rateSel(rateSel),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .running(running), .burstActive(burstActive), .burstRemaining(burstRemaining)
  );

  clkDiagReadback u_readback (
    .diagRead(diagRead), .diagSel(diagSel), .running(running),
    .burstActive(burstActive), .mrReset(mrReset), .rateSel(rateSel),
    .burstRemaining(burstRemaining), .crmDis(crmDis), .edpDis(edpDis),
    .ctlDis(ctlDis), .diagData(diagData), .diagDriving(diagDriving)
  );

endmodule

//--- dv/clkBoardTb.sv
// ----------------------------------------
// Clock board testbench
// Replays the trace, counts gated pulses and
// checks the diagnostic readback
// ----------------------------------------
`timescale 1ns/10ps

module clkBoardTb import clkPkg::*; ();

  localparam int ClkHalf     = 50;     // 100 ns period
  localparam int ResetCycles = 3;
  localparam int TraceDepth  = 64;

  // Trace operations, top nibble of each record
  localparam logic [3:0] opReset  = 4'h1;
  localparam logic [3:0] opCtl    = 4'h2;
  localparam logic [3:0] opLoad   = 4'h3;
  localparam logic [3:0] opWait   = 4'h4;
  localparam logic [3:0] opExpect = 4'h5;
  localparam logic [3:0] opRange  = 4'h6;
  localparam logic [3:0] opRead   = 4'h7;
  localparam logic [3:0] opTest   = 4'h8;
  localparam logic [3:0] opMaster = 4'h9;
  localparam logic [3:0] opEnd    = 4'hf;

  logic     CLK;
  logic     FPGA_RESET;
  logic     diagCtlFunc;
  logic     diagLdFunc;
  diagSelT  diagSel;
  ebusDataT ebusData;
  logic     diagRead;
  logic     eboxClk;
  logic     crmClk;
  logic     edpClk;
  logic     ctlClk;
  logic     mrReset;
  diagWordT diagData;
  logic     diagDriving;

  logic [35:0] traceMem [TraceDepth];
  int          eboxCount;
  int          crmCount;
  int          edpCount;
  int          ctlCount;
  int          failCount  = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;       // Zero until the trace is sized
  string       curTest    = "trace setup";

  clkBoard u_dut (
    .CLK(CLK), .FPGA_RESET(FPGA_RESET),
    .diagCtlFunc(diagCtlFunc), .diagLdFunc(diagLdFunc),
    .diagSel(diagSel), .ebusData(ebusData), .diagRead(diagRead),
    .eboxClk(eboxClk), .crmClk(crmClk), .edpClk(edpClk), .ctlClk(ctlClk),
    .mrReset(mrReset), .diagData(diagData), .diagDriving(diagDriving)
  );

  initial begin
    CLK = 1'b0;
    forever #ClkHalf CLK = ~CLK;
  end

  // Run length guard
  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the trace did not finish within %0d cycles", cycleLimit);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  function automatic string testName(input int num);
    case (num)
      1:       return "reset state";
      2:       return "burst";
      3:       return "single step";
      4:       return "run and stop";
      5:       return "section disables";
      6:       return "master reset and readback";
      default: return $sformatf("test %0d", num);
    endcase
  endfunction

  task automatic checkValue(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      failCount = failCount + 1;
      $display("CHECK FAILED %s: %s expected %0d (0x%0h), actual %0d (0x%0h)",
               curTest, what, expected, expected, actual, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic checkRange(input string what, input int lo, input int hi, input int actual);
    assert (actual >= lo && actual <= hi) else begin
      failCount = failCount + 1;
      $display("CHECK FAILED %s: %s expected %0d to %0d, actual %0d",
               curTest, what, lo, hi, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic applyReset(input int cycles);
    @(negedge CLK);
    FPGA_RESET = 1'b1;
    repeat (cycles) @(negedge CLK);
    FPGA_RESET = 1'b0;
  endtask

  // One-cycle strobes, sampled at the rising edge in between
  task automatic issueCtl(input diagSelT code);
    @(negedge CLK);
    diagSel     = code;
    diagCtlFunc = 1'b1;
    @(negedge CLK);
    diagCtlFunc = 1'b0;
  endtask

  task automatic issueLoad(input diagSelT code, input ebusDataT data);
    @(negedge CLK);
    diagSel    = code;
    ebusData   = data;
    diagLdFunc = 1'b1;
    @(negedge CLK);
    diagLdFunc = 1'b0;
  endtask

  task automatic countPulses(input int cycles);
    eboxCount = 0;
    crmCount  = 0;
    edpCount  = 0;
    ctlCount  = 0;
    repeat (cycles) begin
      @(negedge CLK);                 // Outputs settle after the rising edge
      if (eboxClk) eboxCount = eboxCount + 1;
      if (crmClk) crmCount = crmCount + 1;
      if (edpClk) edpCount = edpCount + 1;
      if (ctlClk) ctlCount = ctlCount + 1;
    end
  endtask

  task automatic readWord(input diagSelT sel, input logic level, input int expDriving,
                          input int expData);
    @(negedge CLK);
    diagSel  = sel;
    diagRead = level;
    @(negedge CLK);
    checkValue($sformatf("select %0d diagDriving", sel), expDriving, int'(diagDriving));
    checkValue($sformatf("select %0d diagData", sel), expData, int'(diagData));
    diagRead = 1'b0;
  endtask

  initial begin
    int          idx;
    int          records;
    int          waitSum;
    logic [35:0] rec;
    logic [3:0]  op;

    FPGA_RESET  = 1'b1;
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    diagSel     = '0;
    ebusData    = '0;
    diagRead    = 1'b0;

    // Unused slots read as end records
    for (idx = 0; idx < TraceDepth; idx++) begin
      traceMem[idx] = {opEnd, 32'(idx)};
    end
    $readmemh("dv/clkBoardTrace.txt", traceMem);

    records = 0;
    waitSum = ResetCycles;
    while (records < TraceDepth && traceMem[records][35:32] != opEnd) begin
      rec = traceMem[records];
      if (rec[35:32] == opWait || rec[35:32] == opReset) begin
        waitSum = waitSum + int'(rec[15:0]);
      end
      records = records + 1;
    end
    if (records == 0) begin
      $display("The trace file dv/clkBoardTrace.txt is missing or holds no records");
      $display("FAIL: see errors above");
      $fatal(1, "no stimulus");
    end
    cycleLimit = 2 * (waitSum + records);

    repeat (ResetCycles) @(negedge CLK);
    FPGA_RESET = 1'b0;

    for (idx = 0; idx < records; idx++) begin
      rec = traceMem[idx];
      op  = rec[35:32];
      case (op)
        opTest:   curTest = testName(int'(rec[7:0]));
        opReset:  applyReset(int'(rec[15:0]));
        opCtl:    issueCtl(diagSelT'(rec[2:0]));
        opLoad:   issueLoad(diagSelT'(rec[10:8]), ebusDataT'(rec[3:0]));
        opWait:   countPulses(int'(rec[15:0]));
        opExpect: begin
          checkValue("eboxClk pulses", int'(rec[31:24]), eboxCount);
          checkValue("crmClk pulses", int'(rec[23:16]), crmCount);
          checkValue("edpClk pulses", int'(rec[15:8]), edpCount);
          checkValue("ctlClk pulses", int'(rec[7:0]), ctlCount);
        end
        opRange:  checkRange("eboxClk pulses", int'(rec[15:8]), int'(rec[7:0]), eboxCount);
        opRead:   readWord(diagSelT'(rec[26:24]), rec[16], int'(rec[8]), int'(rec[5:0]));
        opMaster: checkValue("mrReset", int'(rec[0]), int'(mrReset));
        default: begin
          $display("Trace record %0d holds an unknown operation %0h", idx, op);
          $display("FAIL: see errors above");
          $fatal(1, "bad trace record");
        end
      endcase
    end

    @(negedge CLK);
    if (failCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- dv/clkBoardTrace.txt
// Record: op nibble, then byte fields f3 f2 f1 f0 (9 hex digits)
// 1 RESET f0=cycles | 2 CTL f0=code | 3 LD f1=code f0=data | 4 WAIT f1f0=cycles
// 5 EXPECT ebox crm edp ctl | 6 RANGE f1=lo f0=hi | 7 READ f3=sel f2=read f1=driving f0=data
// 8 TEST f0=number | 9 MR f0=mrReset | F END
800000001 // Reset state
100000003 // RESET 3
40000000a // WAIT 10
500000000 // No pulses
900000000 // mrReset low
700010100 // Status reads zero
701010100 // Burst high reads zero
702010100 // Burst low reads zero
800000002 // Burst
300000400 // Rate 0
300000203 // Count low nibble 3
300000301 // Count high nibble 1
200000005 // Burst 0x13
400000028 // WAIT 40
513131313 // 19 on every section
701010100 // Nothing left
300000200 // Count 0
300000300
200000005 // Empty burst
400000014 // WAIT 20
500000000
800000003 // Single step
300000402 // Rate 2
200000002 // Step
400000014 // WAIT 20
501010101 // Exactly one pulse
800000004 // Run and stop
300000401 // Rate 1
200000001 // Start
400000028 // WAIT 40
600001315 // 19 to 21 pulses
700010121 // Running with rate 1
200000000 // Stop
400000014 // WAIT 20
500000000
700010101 // Idle, rate 1
800000005 // Section disables
300000400 // Rate 0
300000505 // crm and ctl disabled
300000205 // Count 5
300000300
200000005 // Burst 5
400000014 // WAIT 20
505000500 // ebox and edp only
70201010a // Disables in the low word
800000006 // Master reset and readback
200000007 // Set reset
900000001
700010108 // Status bit 3 set
200000006 // Clear reset
900000000
700010100
200000007 // Set again
700000000 // Read low gives nothing
700010108
200000006
F00000000 // END

//--- verilog.f
hw/clkPkg.sv
hw/clkDiagDecode.sv
hw/clkConfigRegs.sv
hw/clkGateControl.sv
hw/clkDiagReadback.sv
hw/clkBoard.sv
dv/clkBoardTb.sv

//--- run.sh
#!/bin/sh
# Build and run the clock board testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f verilog.f --top-module clkBoardTb -o clkBoardSim > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/clkBoardSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if ! grep -q "PASS: all tests" "$SIM_LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
